//--- build.f
+incdir+.
draw_pkg.sv
sine_rom.sv
span_writer.sv
draw_core.sv
draw_top.sv
tb_sdram_model.sv
tb_draw.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the frame-drawing testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_draw -o tb_draw_sim \
  && ./obj_dir/tb_draw_sim > sim.log 2>&1 \
  || { echo "Build or simulation did not complete."; exit 1; }

cat sim.log
grep -q "TESTBENCH PASSED" sim.log && echo "Simulation passed." && exit 0 \
  || { echo "Simulation failed, see sim.log."; exit 1; }

//--- tb_draw.sv
`timescale 1ns/1ps

module tb_draw import draw_pkg::*; ();

  localparam int cycle_limit = 8_000_000; // Two clears at about 5.5 cycles per write.

  logic      clk;
  logic      rst_n;
  logic      en;
  draw_cmd_t cmd;
  logic      draw_done;
  sdram_wr_t wr;
  logic      wr_done;

  int     error_count = 0;
  int     cycles      = 0;
  int     done_pulses = 0;
  logic   idle_phase;              // No activity expected.
  pixel_t ref_frame [scr_pixels];  // Expected image.

  draw_top dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .en        (en),
    .cmd       (cmd),
    .draw_done (draw_done),
    .wr        (wr),
    .wr_done   (wr_done)
  );

  tb_sdram_model mem0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr      (wr),
    .wr_done (wr_done)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk; // 4 ns period.
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (draw_done) done_pulses <= done_pulses + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles, the drawing never finished.", cycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // Protocol checks.
  assert property (@(posedge clk) (!rst_n && cycles > 0) |-> (!wr.req && !draw_done))
    else begin
      error_count++;
      $display("Write request or draw_done seen during reset.");
    end

  assert property (@(posedge clk) disable iff (!rst_n) idle_phase |-> (!wr.req && !draw_done))
    else begin
      error_count++;
      $display("Engine became active on an unknown command.");
    end

  // Request, address and data held until done.
  assert property (@(posedge clk) disable iff (!rst_n)
      (wr.req && !wr_done) |=> (wr.req && $stable(wr.addr) && $stable(wr.data)))
    else begin
      error_count++;
      $display("Write request changed before wr_done.");
    end

  assert property (@(posedge clk) disable iff (!rst_n) wr_done |=> !wr.req)
    else begin
      error_count++;
      $display("Write request still high in the cycle after wr_done.");
    end

  assert property (@(posedge clk) disable iff (!rst_n) wr.req |-> (int'(wr.addr) < scr_pixels))
    else begin
      error_count++;
      $display("Write address %0d lies outside the frame.", wr.addr);
    end

  assert property (@(posedge clk) disable iff (!rst_n) draw_done |=> !draw_done)
    else begin
      error_count++;
      $display("draw_done lasted longer than one cycle.");
    end

  //////////////////////////////
  // Helpers.
  task automatic tick();
    @(posedge clk);
    #1; // Inputs change after the edge.
  endtask

  task automatic check_value(input string name, input int expected, input int actual);
    if (expected != actual) begin
      error_count++;
      $display("error: %s expected %0d actual %0d", name, expected, actual);
    end
  endtask

  task automatic paint(input int start, input int count, input int stride, input pixel_t color);
    for (int i = 0; i < count; i++) ref_frame[start + i * stride] = color;
  endtask

  // round(63*sin(2*pi*k/120)), k in 0..30.
  function automatic int quarter_sine(input int k);
    real pi = 3.14159265358979;
    return $rtoi(63.0 * $sin(2.0 * pi * k / 120.0) + 0.5);
  endfunction

  function automatic int sine_ref(input int k);
    if (k <= 30) return 63 + quarter_sine(k);
    else if (k <= 60) return 63 + quarter_sine(60 - k);
    else if (k <= 90) return 63 - quarter_sine(k - 60);
    return 63 - quarter_sine(120 - k);
  endfunction

  task automatic paint_image();
    paint(4810, 461, 1, color_green);      // Top.
    paint(379210, 461, 1, color_green);    // Bottom.
    paint(4810, 781, 480, color_green);    // Left.
    paint(5270, 781, 480, color_green);    // Right.
    paint(5040, 781, 480, color_yellow);   // Center.
    paint(48300, 501, 480, color_pink);    // Axis.
  endtask

  task automatic paint_sine();
    paint(48300, 501, 480, color_pink);
    for (int y = 100; y < 700; y++) begin
      ref_frame[y * 480 + 250 + sine_ref((y - 100) % 120)] = color_pink; // One point per row.
    end
  endtask

  task automatic compare_frame(input string name);
    int bad;
    bad = 0;
    for (int i = 0; i < scr_pixels; i++) begin
      if (mem0.frame[i] !== ref_frame[i]) begin
        if (bad < 5) begin
          $display("error: %s pixel %0d expected %h actual %h", name, i, ref_frame[i],
                   mem0.frame[i]);
        end
        bad++;
      end
    end
    error_count += bad;
  endtask

  // Start a drawing and wait for draw_done; optional cmd change midway.
  task automatic run_drawing(input draw_cmd_t code, input string name, input int exp_writes,
                             input bit change_cmd);
    int start_writes;
    int start_pulses;
    int waited;
    start_writes = mem0.write_count;
    start_pulses = done_pulses;
    waited       = 0;
    cmd = code;
    en  = 1'b1;
    do begin
      tick();
      waited++;
      if (change_cmd && waited == 100) cmd = cmd_clear; // Must not disturb the drawing.
    end while (!draw_done);
    en = 1'b0;
    check_value({name, " writes"}, exp_writes, mem0.write_count - start_writes);
    repeat (20) tick();
    check_value({name, " done pulses"}, 1, done_pulses - start_pulses);
    check_value({name, " writes after done"}, exp_writes, mem0.write_count - start_writes);
  endtask

  task automatic fill_clear();
    for (int i = 0; i < scr_pixels; i++) ref_frame[i] = color_clear;
  endtask

  //////////////////////////////
  // Test sequence.
  initial begin
    rst_n      = 1'b0;
    en         = 1'b0;
    cmd        = cmd_clear;
    idle_phase = 1'b0;
    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;

    idle_phase = 1'b1; // Unknown command.
    en         = 1'b1;
    cmd        = 4'd3;
    repeat (200) tick();
    idle_phase = 1'b0;
    en         = 1'b0;
    check_value("idle writes", 0, mem0.write_count);
    check_value("idle done pulses", 0, done_pulses);

    run_drawing(cmd_clear, "clear", scr_pixels, 1'b0);
    fill_clear();
    compare_frame("clear");

    paint_image();
    run_drawing(cmd_image, "image", 461 + 461 + 781 + 781 + 781 + 501, 1'b0);
    compare_frame("image");
    run_drawing(cmd_image, "latch", 461 + 461 + 781 + 781 + 781 + 501, 1'b1);
    compare_frame("latch");

    run_drawing(cmd_clear, "second clear", scr_pixels, 1'b0);
    fill_clear();
    paint_sine();
    run_drawing(cmd_sine, "sine", 501 + 600, 1'b0);
    compare_frame("sine");

    $display("Run finished with %0d errors.", error_count);
    if (error_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- tb_sdram_model.sv
`timescale 1ns/1ps

module tb_sdram_model import draw_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  sdram_wr_t wr,
  output logic      wr_done  // One-cycle pulse per write.
);

  pixel_t frame [scr_pixels]; // Frame buffer, one word per pixel.
  int     write_count;        // Completed writes.
  integer seed = 5279;        // Seed for the response delay.
  int     wait_left;          // Cycles left before done.
  logic   active;             // Request accepted, done pending.

  //////////////////////////////
  // Write response.
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_done     <= 1'b0;
      active      <= 1'b0;
      wait_left   <= 0;
      write_count <= 0;
    end else begin
      wr_done <= 1'b0;
      if (wr_done) begin
        // Request drops in this cycle.
      end else if (!active && wr.req) begin
        active    <= 1'b1;
        wait_left <= 1 + int'($unsigned($random(seed)) % 4); // 1 to 4 cycles.
      end else if (active) begin
        if (wait_left == 1) begin
          wr_done     <= 1'b1;
          active      <= 1'b0;
          write_count <= write_count + 1;
          if (int'(wr.addr) < scr_pixels) begin
            frame[int'(wr.addr)] <= wr.data; // Out of range writes are dropped.
          end
        end else begin
          wait_left <= wait_left - 1;
        end
      end
    end
  end

endmodule

//--- draw_top.sv
`timescale 1ns/1ps

module draw_top import draw_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      en,
  input  draw_cmd_t cmd,
  output logic      draw_done,
  output sdram_wr_t wr,
  input  logic      wr_done
);

  // Sequencer to span writer.
  span_t      span;
  logic       span_start;
  logic       span_busy;
  logic       span_done;

  // Sequencer to sine ROM.
  logic [6:0] sine_idx;
  logic [6:0] sine_val;

  draw_core u_core (
    .clk        (clk),
    .rst_n      (rst_n),
    .en         (en),
    .cmd        (cmd),
    .draw_done  (draw_done),
    .sine_idx   (sine_idx),
    .sine_val   (sine_val),
    .span       (span),
    .span_start (span_start),
    .span_busy  (span_busy),
    .span_done  (span_done)
  );

  sine_rom u_rom (
    .clk (clk),
    .idx (sine_idx),
    .val (sine_val)
  );

  span_writer u_writer (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (span_start),
    .span    (span),
    .busy    (span_busy),
    .done    (span_done),
    .wr      (wr),
    .wr_done (wr_done)
  );

endmodule

//--- draw_core.sv
`timescale 1ns/1ps

module draw_core import draw_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       en,
  input  draw_cmd_t  cmd,
  output logic       draw_done,  // Pulse at end of drawing.
  output logic [6:0] sine_idx,
  input  logic [6:0] sine_val,   // Valid one cycle after sine_idx.
  output span_t      span,
  output logic       span_start,
  input  logic       span_busy,
  input  logic       span_done
);

  typedef enum logic [1:0] {
    st_idle,   // Waiting for en.
    st_rom,    // Sine ROM read.
    st_issue,  // Hand span to writer.
    st_wait    // Span in progress.
  } core_state_t;

  core_state_t state;
  draw_cmd_t   cmd_q;     // Latched command.
  logic [2:0]  step;      // Span index within the program.
  logic [9:0]  point;     // Sine point 0..599.
  sdram_addr_t row_base;  // Row address of the current sine point.
  span_t       next_span;
  logic        cmd_valid;
  logic        last_span;

  assign cmd_valid = (cmd == cmd_clear) || (cmd == cmd_image) || (cmd == cmd_sine);

  //////////////////////////////
  // Program tables.
  always_comb begin
    next_span = span_axis;
    case (cmd_q)
      cmd_clear: next_span = span_clear;
      cmd_image: begin
        case (step)
          3'd0:    next_span = span_img_top;
          3'd1:    next_span = span_img_bottom;
          3'd2:    next_span = span_img_left;
          3'd3:    next_span = span_img_right;
          3'd4:    next_span = span_img_center;
          default: next_span = span_axis; // Axis closes the image.
        endcase
      end
      default: begin
        if (step != 3'd0) begin           // Single sine point after the axis.
          next_span.start  = row_base + sdram_addr_t'(sine_x0) + {17'd0, sine_val};
          next_span.count  = 24'd1;
          next_span.stride = 10'd1;
          next_span.color  = color_pink;
        end
      end
    endcase
  end

  always_comb begin
    case (cmd_q)
      cmd_clear: last_span = 1'b1;
      cmd_image: last_span = (step == 3'd5);
      default:   last_span = (step != 3'd0) && (point == 10'(sine_points - 1));
    endcase
  end

  //////////////////////////////
  // Sequencer.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= st_idle;
      cmd_q      <= cmd_clear;
      step       <= '0;
      point      <= '0;
      sine_idx   <= '0;
      row_base   <= '0;
      span_start <= 1'b0;
      draw_done  <= 1'b0;
    end else begin
      span_start <= 1'b0;
      draw_done  <= 1'b0;
      case (state)
        st_idle: begin
          if (en && cmd_valid) begin  // Other codes keep the core idle.
            cmd_q    <= cmd;
            step     <= '0;
            point    <= '0;
            sine_idx <= '0;
            row_base <= sdram_addr_t'(sine_row0);
            state    <= st_issue;
          end
        end
        st_rom: state <= st_issue;    // sine_val settles here.
        st_issue: begin
          if (!span_busy) begin
            span_start <= 1'b1;
            state      <= st_wait;
          end
        end
        st_wait: begin
          if (span_done) begin
            if (last_span) begin
              draw_done <= 1'b1;
              state     <= st_idle;
            end else if (cmd_q == cmd_image) begin
              step  <= step + 3'd1;
              state <= st_issue;
            end else if (step == 3'd0) begin
              step  <= 3'd1;         // Axis drawn, points follow.
              state <= st_rom;
            end else begin
              point    <= point + 10'd1;
              sine_idx <= (sine_idx == 7'(sine_period - 1)) ? 7'd0 : sine_idx + 7'd1;
              row_base <= row_base + sdram_addr_t'(scr_width); // Next row.
              state    <= st_rom;
            end
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Span fields load with span_start.
  always_ff @(posedge clk) begin
    if (state == st_issue && !span_busy) begin
      span <= next_span;
    end
  end

endmodule

//--- span_writer.sv
`timescale 1ns/1ps

module span_writer import draw_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      start,   // One-cycle span request.
  input  span_t     span,    // Captured at start.
  output logic      busy,
  output logic      done,    // Pulse after last pixel.
  output sdram_wr_t wr,
  input  logic      wr_done  // Pulse from SDRAM controller.
);

  typedef enum logic [1:0] {
    st_idle,
    st_request,
    st_step
  } wr_state_t;

  wr_state_t   state;
  logic [23:0] remain; // Pixels left including the current one.
  logic        req;
  sdram_addr_t addr;   // Current pixel address.
  logic [9:0]  stride;
  pixel_t      color;
  logic        last;   // Current pixel ends the span.

  assign last = (remain == 24'd1);

  //////////////////////////////
  // Control path.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= st_idle;
      req    <= 1'b0;
      busy   <= 1'b0;
      done   <= 1'b0;
      remain <= '0;
    end else begin
      done <= 1'b0; // Pulse by default.
      case (state)
        st_idle: begin
          if (start) begin
            remain <= span.count;
            req    <= 1'b1;      // First request one cycle after start.
            busy   <= 1'b1;
            state  <= st_request;
          end
        end
        st_request: begin
          if (wr_done) begin     // Hold request until controller is done.
            req   <= 1'b0;
            state <= st_step;
          end
        end
        st_step: begin
          if (last) begin
            done  <= 1'b1;       // Busy drops with done.
            busy  <= 1'b0;
            state <= st_idle;
          end else begin
            remain <= remain - 24'd1;
            req    <= 1'b1;
            state  <= st_request;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  //////////////////////////////
  // Address and data.
  always_ff @(posedge clk) begin
    if (state == st_idle && start) begin
      addr   <= span.start;
      stride <= span.stride;
      color  <= span.color;
    end else if (state == st_step && !last) begin
      addr <= addr + {14'd0, stride}; // Next pixel of the span.
    end
  end

  assign wr.addr = addr;
  assign wr.data = color;
  assign wr.req  = req;

endmodule

//--- sine_rom.sv
`timescale 1ns/1ps

module sine_rom import draw_pkg::*; (
  input  logic       clk,
  input  logic [6:0] idx, // Sample 0..119.
  output logic [6:0] val  // Plot offset 0..126.
);

  logic [4:0] tab_idx; // Quarter-wave index 0..30.
  logic       neg;     // Lower half of the period.
  logic [5:0] q;       // Quarter-wave magnitude.

  // Fold the sample into a quadrant.
  always_comb begin
    if (idx <= 7'(sine_quarter)) begin
      tab_idx = 5'(idx);                            // Rising from zero.
      neg     = 1'b0;
    end else if (idx <= 7'(2 * sine_quarter)) begin
      tab_idx = 5'(7'(2 * sine_quarter) - idx);     // Falling to zero.
      neg     = 1'b0;
    end else if (idx <= 7'(3 * sine_quarter)) begin
      tab_idx = 5'(idx - 7'(2 * sine_quarter));     // Falling below zero.
      neg     = 1'b1;
    end else begin
      tab_idx = 5'(7'(sine_period) - idx);          // Rising back to zero.
      neg     = 1'b1;
    end
  end

  // round(63*sin(2*pi*k/120)) for k = 0..30.
  always_comb begin
    case (tab_idx)
      5'd0:    q = 6'd0;
      5'd1:    q = 6'd3;
      5'd2:    q = 6'd7;
      5'd3:    q = 6'd10;
      5'd4:    q = 6'd13;
      5'd5:    q = 6'd16;
      5'd6:    q = 6'd19;
      5'd7:    q = 6'd23;
      5'd8:    q = 6'd26;
      5'd9:    q = 6'd29;
      5'd10:   q = 6'd31;
      5'd11:   q = 6'd34;
      5'd12:   q = 6'd37;
      5'd13:   q = 6'd40;
      5'd14:   q = 6'd42;
      5'd15:   q = 6'd45;
      5'd16:   q = 6'd47;
      5'd17:   q = 6'd49;
      5'd18:   q = 6'd51;
      5'd19:   q = 6'd53;
      5'd20:   q = 6'd55;
      5'd21:   q = 6'd56;
      5'd22:   q = 6'd58;
      5'd23:   q = 6'd59;
      5'd24:   q = 6'd60;
      5'd25:   q = 6'd61;
      5'd26:   q = 6'd62;
      5'd27:   q = 6'd62;
      5'd28:   q = 6'd63;
      5'd29:   q = 6'd63;
      5'd30:   q = 6'd63;
      default: q = 6'd0; // Unused entry.
    endcase
  end

  // Registered read, one cycle like a block RAM.
  always_ff @(posedge clk) begin
    val <= neg ? 7'(sine_amp) - {1'b0, q} : 7'(sine_amp) + {1'b0, q};
  end

endmodule

//--- draw_pkg.sv
package draw_pkg;

  `include "color_table.svh"

  //////////////////////////////
  // Screen geometry.
  localparam int scr_width  = 480;                    // Pixels per row.
  localparam int scr_height = 800;                    // Rows.
  localparam int scr_pixels = scr_width * scr_height; // 384000 pixels.

  // Sine plot geometry.
  localparam int sine_period  = 120;                       // Samples per period.
  localparam int sine_periods = 5;
  localparam int sine_points  = sine_period * sine_periods; // One point per row.
  localparam int sine_quarter = sine_period / 4;            // Quarter-wave length.
  localparam int sine_amp     = 63;                         // Mid level and amplitude.
  localparam int sine_x0      = 250;                        // Left edge of plot.
  localparam int sine_y0      = 100;                        // First plot row.
  localparam int sine_row0    = sine_y0 * scr_width;        // Address of first plot row.

  //////////////////////////////
  // Types.
  typedef logic [23:0] sdram_addr_t; // y*480+x, Bank(2)+Row(13)+Column(9).
  typedef logic [15:0] pixel_t;      // RGB565.
  typedef logic [3:0]  draw_cmd_t;

  localparam draw_cmd_t cmd_clear = 4'd0; // Clear screen.
  localparam draw_cmd_t cmd_image = 4'd1; // Fixed test image.
  localparam draw_cmd_t cmd_sine  = 4'd2; // Sine plot.

  // One run of equally spaced pixels.
  typedef struct packed {
    sdram_addr_t start;  // First pixel.
    logic [23:0] count;  // Pixels, at least one.
    logic [9:0]  stride; // 1 for rows, 480 for columns.
    pixel_t      color;
  } span_t;

  // SDRAM write port.
  typedef struct packed {
    sdram_addr_t addr;
    pixel_t      data;
    logic        req;
  } sdram_wr_t;

  //////////////////////////////
  // Fixed spans of the drawing programs.
  localparam span_t span_clear = '{start: '0, count: 24'(scr_pixels),
                                   stride: 10'd1, color: color_clear};
  // (10,10) to (470,10).
  localparam span_t span_img_top = '{start: sdram_addr_t'(10 * scr_width + 10),
                                     count: 24'd461, stride: 10'd1, color: color_green};
  // (10,790) to (470,790).
  localparam span_t span_img_bottom = '{start: sdram_addr_t'(790 * scr_width + 10),
                                        count: 24'd461, stride: 10'd1, color: color_green};
  // (10,10) to (10,790).
  localparam span_t span_img_left = '{start: sdram_addr_t'(10 * scr_width + 10),
                                      count: 24'd781, stride: 10'(scr_width),
                                      color: color_green};
  // (470,10) to (470,790).
  localparam span_t span_img_right = '{start: sdram_addr_t'(10 * scr_width + 470),
                                       count: 24'd781, stride: 10'(scr_width),
                                       color: color_green};
  // (240,10) to (240,790).
  localparam span_t span_img_center = '{start: sdram_addr_t'(10 * scr_width + 240),
                                        count: 24'd781, stride: 10'(scr_width),
                                        color: color_yellow};
  // Axis (300,100) to (300,600).
  localparam span_t span_axis = '{start: sdram_addr_t'(100 * scr_width + 300),
                                  count: 24'd501, stride: 10'(scr_width),
                                  color: color_pink};

endpackage

//--- color_table.svh
`ifndef color_table_svh
`define color_table_svh

// RGB565 colors drawn by the engine.
// Layout is R[15:11] G[10:5] B[4:0].

localparam logic [15:0] color_clear  = 16'h1986; // Background.
localparam logic [15:0] color_green  = 16'h07E0; // Frame lines.
localparam logic [15:0] color_yellow = 16'hFFE0; // Center line.
localparam logic [15:0] color_pink   = 16'hF81F; // Axis and sine wave.

`endif
